// File: source/rv32_pkg.sv
// RV32I shared definitions
`default_nettype none

package rv32_pkg;

  // Data words and addresses
  typedef logic [31:0] word_t;
  // Register index
  typedef logic [4:0] reg_addr_t;
  // Major opcode field
  typedef logic [6:0] opcode_t;
  // Write-back source code
  typedef logic [1:0] wb_sel_t;

  // Supported major opcodes
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // Write-back sources
  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_PC4  = 2'd1;
  localparam wb_sel_t WB_LOAD = 2'd2;
  localparam wb_sel_t WB_IMM  = 2'd3;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // Signedness of loads travels on its own flag
  typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

endpackage

`default_nettype wire

// File: source/decode_if.sv
// Decoded control bundle
`timescale 1ns/1ns
`default_nettype none

interface decode_if;
  import rv32_pkg::*;

  alu_op_t   alu_op;
  // High selects pc as operand a
  logic      alu_a_sel;
  // High selects the immediate as operand b
  logic      alu_b_sel;
  // Sign-extended immediate for the decoded format
  word_t     imm;
  wb_sel_t   w_sel;
  logic      reg_wen;
  logic      is_branch, is_jump, jump_reg;
  logic      mem_ren, mem_wen;
  mem_size_t mem_size;
  logic      load_unsigned;
  logic      halt_req;
  logic [2:0] funct3;

  modport ctrl (
    output alu_op, alu_a_sel, alu_b_sel, imm, w_sel, reg_wen,
    output is_branch, is_jump, jump_reg, mem_ren, mem_wen, mem_size,
    output load_unsigned, halt_req, funct3
  );

  modport dp (
    input alu_op, alu_a_sel, alu_b_sel, imm, w_sel, reg_wen,
    input is_branch, is_jump, jump_reg, mem_ren, mem_wen, mem_size,
    input load_unsigned, halt_req, funct3
  );

endinterface

`default_nettype wire

// File: source/alu.sv
// RV32I integer ALU
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv32_pkg::alu_op_t op,
  input  rv32_pkg::word_t   a,
  input  rv32_pkg::word_t   b,
  output rv32_pkg::word_t   y
);
  import rv32_pkg::*;

  logic [4:0] shamt;

  // Only the low five bits of b shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_SLL:  y = a << shamt;
      ALU_SLT:  y = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: y = {31'b0, a < b};
      ALU_XOR:  y = a ^ b;
      ALU_SRL:  y = a >> shamt;
      ALU_SRA:  y = $signed(a) >>> shamt;
      ALU_OR:   y = a | b;
      ALU_AND:  y = a & b;
      default:  y = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: source/reg_file.sv
// RV32I register file
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                clk,
  input  logic                reset,
  input  rv32_pkg::reg_addr_t rs1,
  input  rv32_pkg::reg_addr_t rs2,
  input  rv32_pkg::reg_addr_t rd,
  input  logic                wen,
  input  rv32_pkg::word_t     w_data,
  output rv32_pkg::word_t     rs1_data,
  output rv32_pkg::word_t     rs2_data
);
  import rv32_pkg::*;

  word_t regs [32];

  // Write at the edge, x0 never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin
      regs[rd] <= w_data;
    end
  end

  // Combinational reads, x0 hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/control_unit.sv
// RV32I instruction decoder
`timescale 1ns/1ns
`default_nettype none

module control_unit (
  input rv32_pkg::word_t instr,
  decode_if.ctrl         dec
);
  import rv32_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_t    arith_op;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // OP and OP-IMM operation from funct3, bit 30 picks sub and sra
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    // Defaults leave an unknown opcode without any effect
    dec.alu_op        = ALU_ADD;
    dec.alu_a_sel     = 1'b0;
    dec.alu_b_sel     = 1'b1;
    dec.imm           = imm_i;
    dec.w_sel         = WB_ALU;
    dec.reg_wen       = 1'b0;
    dec.is_branch     = 1'b0;
    dec.is_jump       = 1'b0;
    dec.jump_reg      = 1'b0;
    dec.mem_ren       = 1'b0;
    dec.mem_wen       = 1'b0;
    dec.load_unsigned = funct3[2];
    dec.halt_req      = 1'b0;
    dec.funct3        = funct3;
    // Loads and stores share the size encoding in funct3
    case (funct3[1:0])
      2'b00:   dec.mem_size = MEM_BYTE;
      2'b01:   dec.mem_size = MEM_HALF;
      default: dec.mem_size = MEM_WORD;
    endcase
    case (opcode)
      OPC_LUI: begin
        dec.imm     = imm_u;
        dec.w_sel   = WB_IMM;
        dec.reg_wen = 1'b1;
      end
      OPC_AUIPC: begin
        dec.imm       = imm_u;
        dec.alu_a_sel = 1'b1;
        dec.reg_wen   = 1'b1;
      end
      OPC_JAL: begin
        dec.imm     = imm_j;
        dec.w_sel   = WB_PC4;
        dec.reg_wen = 1'b1;
        dec.is_jump = 1'b1;
      end
      OPC_JALR: begin
        dec.w_sel    = WB_PC4;
        dec.reg_wen  = 1'b1;
        dec.is_jump  = 1'b1;
        dec.jump_reg = 1'b1;
      end
      OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
      end
      OPC_LOAD: begin
        dec.w_sel   = WB_LOAD;
        dec.reg_wen = 1'b1;
        dec.mem_ren = 1'b1;
      end
      OPC_STORE: begin
        dec.imm     = imm_s;
        dec.mem_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        // Shift amount sits in the low five immediate bits
        dec.alu_op  = arith_op;
        dec.reg_wen = 1'b1;
      end
      OPC_OP: begin
        dec.alu_op    = arith_op;
        dec.alu_b_sel = 1'b0;
        dec.reg_wen   = 1'b1;
      end
      OPC_SYSTEM: dec.halt_req = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/branch_res.sv
// Branch condition and target
`timescale 1ns/1ns
`default_nettype none

module branch_res (
  decode_if.dp            dec,
  input  rv32_pkg::word_t rs1_data,
  input  rv32_pkg::word_t rs2_data,
  input  rv32_pkg::word_t pc,
  output logic            taken,
  output rv32_pkg::word_t target
);

  logic cond;

  // funct3 selects the comparison
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_data == rs2_data);
      3'b001:  cond = (rs1_data != rs2_data);
      3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  cond = (rs1_data < rs2_data);
      3'b111:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  // Taken only for real branches
  assign taken  = dec.is_branch & cond;
  // B-immediate arrives on the shared imm field
  assign target = pc + dec.imm;

endmodule

`default_nettype wire

// File: source/data_memory.sv
// Byte-enabled data memory
`timescale 1ns/1ns
`default_nettype none

module data_memory #(
  parameter int DMEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            accept,
  decode_if.dp            dec,
  input  rv32_pkg::word_t addr,
  input  rv32_pkg::word_t wdata,
  output rv32_pkg::word_t rdata
);
  import rv32_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  word_t            mem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [1:0]       offset;
  logic [3:0]       byte_en;
  word_t            wlanes;
  word_t            rword;
  logic [7:0]       rbyte;
  logic [15:0]      rhalf;

  // Word index wraps modulo the memory size
  assign idx    = addr[IDX_W+1:2];
  assign offset = addr[1:0];

  // Lane enables, misaligned half or word enables nothing
  always_comb begin
    byte_en = 4'b0000;
    case (dec.mem_size)
      MEM_BYTE: byte_en = 4'b0001 << offset;
      MEM_HALF: begin
        if (!offset[0]) begin
          byte_en = offset[1] ? 4'b1100 : 4'b0011;
        end
      end
      MEM_WORD: begin
        if (offset == 2'b00) begin
          byte_en = 4'b1111;
        end
      end
      default: byte_en = 4'b0000;
    endcase
  end

  // Replicate store data across all lanes
  always_comb begin
    case (dec.mem_size)
      MEM_BYTE: wlanes = {4{wdata[7:0]}};
      MEM_HALF: wlanes = {2{wdata[15:0]}};
      default:  wlanes = wdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (accept && dec.mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) begin
          mem[idx][8*b +: 8] <= wlanes[8*b +: 8];
        end
      end
    end
  end

  assign rword = mem[idx];
  assign rbyte = rword[{offset, 3'b000} +: 8];
  assign rhalf = offset[1] ? rword[31:16] : rword[15:0];

  // Lane select and extension, zero when misaligned or not a load
  always_comb begin
    rdata = '0;
    if (dec.mem_ren && byte_en != 4'b0000) begin
      case (dec.mem_size)
        MEM_BYTE: rdata = dec.load_unsigned ? {24'b0, rbyte} : {{24{rbyte[7]}}, rbyte};
        MEM_HALF: rdata = dec.load_unsigned ? {16'b0, rhalf} : {{16{rhalf[15]}}, rhalf};
        default:  rdata = rword;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
// RV32I execute stage
`timescale 1ns/1ns
`default_nettype none

module execute_stage #(
  parameter int DMEM_WORDS = 64
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  rv32_pkg::word_t     instr,
  input  rv32_pkg::word_t     pc,
  input  logic                prediction,
  output logic                result_valid,
  output logic                wb_en,
  output rv32_pkg::reg_addr_t wb_rd,
  output rv32_pkg::word_t     wb_data,
  output rv32_pkg::word_t     next_pc,
  output logic                mispredict,
  output logic                halt
);
  import rv32_pkg::*;

  decode_if dec ();

  reg_addr_t rs1, rs2, rd;
  word_t     rs1_data, rs2_data;
  word_t     alu_a, alu_b, alu_y;
  word_t     br_target, jump_target, pc4, npc;
  word_t     load_data, w_data;
  logic      accept, br_taken, reg_we;

  // Nothing is accepted once halted
  assign accept = instr_valid & ~halt;

  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign rd  = instr[11:7];
  assign pc4 = pc + 32'd4;

  control_unit u_ctrl (
    .instr (instr),
    .dec   (dec.ctrl)
  );

  // Register write lands at the accepting edge
  assign reg_we = accept & dec.reg_wen;

  reg_file u_rf (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .wen      (reg_we),
    .w_data   (w_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // Operand muxes
  assign alu_a = dec.alu_a_sel ? pc : rs1_data;
  assign alu_b = dec.alu_b_sel ? dec.imm : rs2_data;

  alu u_alu (
    .op (dec.alu_op),
    .a  (alu_a),
    .b  (alu_b),
    .y  (alu_y)
  );

  branch_res u_br (
    .dec      (dec.dp),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .taken    (br_taken),
    .target   (br_target)
  );

  // Address comes from rs1 + imm on the ALU
  data_memory #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .clk    (clk),
    .reset  (reset),
    .accept (accept),
    .dec    (dec.dp),
    .addr   (alu_y),
    .wdata  (rs2_data),
    .rdata  (load_data)
  );

  // JALR clears bit 0 of rs1 + imm
  assign jump_target = dec.jump_reg ? ((rs1_data + dec.imm) & ~32'd1) : (pc + dec.imm);

  always_comb begin
    if (dec.is_jump) begin
      npc = jump_target;
    end else if (br_taken) begin
      npc = br_target;
    end else begin
      npc = pc4;
    end
  end

  always_comb begin
    case (dec.w_sel)
      WB_ALU:  w_data = alu_y;
      WB_PC4:  w_data = pc4;
      WB_LOAD: w_data = load_data;
      default: w_data = dec.imm;
    endcase
  end

  // Control outputs, one cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      wb_en        <= 1'b0;
      mispredict   <= 1'b0;
      halt         <= 1'b0;
    end else begin
      result_valid <= accept;
      wb_en        <= reg_we & (rd != '0);
      // Only branches can mispredict
      mispredict   <= accept & dec.is_branch & (prediction ^ br_taken);
      // Sticky until reset
      if (accept && dec.halt_req) begin
        halt <= 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (accept) begin
      wb_rd   <= rd;
      wb_data <= w_data;
      next_pc <= npc;
    end
  end

endmodule

`default_nettype wire

// File: testbench/execute_properties.sv
// Execute stage output properties
`timescale 1ns/1ns
`default_nettype none

module execute_properties (
  input logic clk,
  input logic reset,
  input logic instr_valid,
  input logic result_valid,
  input logic wb_en,
  input logic mispredict,
  input logic halt
);

  // Write enable and mispredict only travel with a result
  flags_need_valid: assert property (@(posedge clk) disable iff (reset)
    (mispredict || wb_en) |-> result_valid)
    else $error("wb_en or mispredict high without result_valid");

  // No accepted strobe means no result next cycle
  valid_needs_strobe: assert property (@(posedge clk) disable iff (reset)
    !(instr_valid && !halt) |=> !result_valid)
    else $error("result_valid without an accepted strobe");

  // Halt is sticky
  halt_sticky: assert property (@(posedge clk) disable iff (reset)
    halt |=> halt)
    else $error("halt dropped without reset");

  // Reset clears the control outputs
  reset_clears: assert property (@(posedge clk)
    reset |=> !result_valid && !wb_en && !mispredict && !halt)
    else $error("control output high after reset");

endmodule

bind execute_stage execute_properties u_props (
  .clk          (clk),
  .reset        (reset),
  .instr_valid  (instr_valid),
  .result_valid (result_valid),
  .wb_en        (wb_en),
  .mispredict   (mispredict),
  .halt         (halt)
);

`default_nettype wire

// File: testbench/execute_tb.sv
// Execute stage testbench
`timescale 1ns/1ns
`default_nettype none

module execute_tb;
  import rv32_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int DMEM_WORDS = 64;
  localparam int N_RANDOM   = 2000;
  // Random stream, register sweep, memory sweep, halt and post-halt strobes
  localparam int N_TOTAL    = N_RANDOM + 31 + DMEM_WORDS + 1 + 16;
  localparam int TIMEOUT_NS = (N_TOTAL * 2 + 100) * CLK_PERIOD;

  logic      clk;
  logic      reset;
  logic      instr_valid;
  word_t     instr;
  word_t     pc;
  logic      prediction;
  logic      result_valid;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  word_t     next_pc;
  logic      mispredict;
  logic      halt;

  int seed = 40;

  // Reference state
  word_t model_regs [32];
  word_t model_mem [DMEM_WORDS];
  logic  model_halt;

  // Expected outputs one cycle after the strobe
  logic      exp_valid;
  logic      exp_wen;
  logic      exp_misp;
  logic      exp_halt;
  reg_addr_t exp_rd;
  word_t     exp_data;
  word_t     exp_npc;

  execute_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dut (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .pc           (pc),
    .prediction   (prediction),
    .result_valid (result_valid),
    .wb_en        (wb_en),
    .wb_rd        (wb_rd),
    .wb_data      (wb_data),
    .next_pc      (next_pc),
    .mispredict   (mispredict),
    .halt         (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Hard limit on the run
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the instruction stream did not complete in time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  // Uniform value in 0 .. n-1
  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Byte offset into the memory, mostly aligned to the access size
  function automatic logic [11:0] mem_offset(input logic [1:0] size);
    logic [11:0] off;
    off = 12'(rand_below(4 * DMEM_WORDS));
    if (rand_below(8) != 0) begin
      if (size == 2'd1) begin
        off[0] = 1'b0;
      end else if (size == 2'd2) begin
        off[1:0] = 2'b00;
      end
    end
    return off;
  endfunction

  // One random instruction from the supported set
  task automatic gen_instr(output word_t ins);
    word_t       r;
    reg_addr_t   rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    int          kind;
    r     = word_t'($random(seed));
    rd    = reg_addr_t'(rand_below(32));
    rs1   = reg_addr_t'(rand_below(32));
    rs2   = reg_addr_t'(rand_below(32));
    f3    = 3'(rand_below(8));
    kind  = rand_below(16);
    imm12 = r[11:0];
    case (kind)
      0, 1, 2: begin
        // funct7 0x20 only for sub and sra
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00;
        ins = {f7, rs2, rs1, f3, rd, OPC_OP};
      end
      3, 4, 5: begin
        if (f3 == 3'd1) begin
          imm12[11:5] = 7'h00;
        end else if (f3 == 3'd5) begin
          imm12[11:5] = (rand_below(2) == 1) ? 7'h20 : 7'h00;
        end
        ins = {imm12, rs1, f3, rd, OPC_OP_IMM};
      end
      6: ins = {r[31:12], rd, OPC_LUI};
      7: ins = {r[31:12], rd, OPC_AUIPC};
      8: ins = {r[31:12], rd, OPC_JAL};
      9: ins = {imm12, rs1, 3'b000, rd, OPC_JALR};
      10, 11: begin
        // Map 0..5 onto beq bne blt bge bltu bgeu
        f3 = 3'(rand_below(6));
        if (f3 >= 3'd2) begin
          f3 = f3 + 3'd2;
        end
        ins = {r[31:25], rs2, rs1, f3, r[11:7], OPC_BRANCH};
      end
      12, 13: begin
        // Map 0..4 onto lb lh lw lbu lhu
        f3 = 3'(rand_below(5));
        if (f3 >= 3'd3) begin
          f3 = f3 + 3'd1;
        end
        imm12 = mem_offset(f3[1:0]);
        ins = {imm12, 5'd0, f3, rd, OPC_LOAD};
      end
      default: begin
        f3    = 3'(rand_below(3));
        imm12 = mem_offset(f3[1:0]);
        ins   = {imm12[11:5], rs2, 5'd0, f3, imm12[4:0], OPC_STORE};
      end
    endcase
  endtask

  // Integer operation by funct3, alt selects sub or sra
  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0: begin
        if (alt) begin
          return a - b;
        end
        return a + b;
      end
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Little-endian load, misaligned halves and words give zero
  function automatic word_t load_ref(input logic [2:0] f3, input word_t addr);
    word_t       w;
    logic [7:0]  bt;
    logic [15:0] hf;
    w  = model_mem[addr[7:2]];
    bt = w[{addr[1:0], 3'b000} +: 8];
    hf = w[{addr[1], 4'b0000} +: 16];
    case (f3)
      3'd0: return {{24{bt[7]}}, bt};
      3'd4: return {24'd0, bt};
      3'd1: return addr[0] ? 32'd0 : {{16{hf[15]}}, hf};
      3'd5: return addr[0] ? 32'd0 : {16'd0, hf};
      default: return (addr[1:0] != 2'b00) ? 32'd0 : w;
    endcase
  endfunction

  // Misaligned stores leave memory untouched
  task automatic store_ref(input logic [2:0] f3, input word_t addr, input word_t data);
    case (f3)
      3'd0: model_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      3'd1: begin
        if (!addr[0]) begin
          model_mem[addr[7:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
        end
      end
      default: begin
        if (addr[1:0] == 2'b00) begin
          model_mem[addr[7:2]] = data;
        end
      end
    endcase
  endtask

  // Advance the model by one presented instruction
  task automatic predict(input logic v, input word_t ins, input word_t ipc, input logic pred);
    word_t      a, b, res, imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0] f3;
    logic       wr, taken;
    reg_addr_t  rd;
    f3    = ins[14:12];
    rd    = ins[11:7];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {ins[31:12], 12'd0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    exp_valid = v && !model_halt;
    exp_wen   = 1'b0;
    exp_misp  = 1'b0;
    exp_rd    = rd;
    exp_npc   = ipc + 32'd4;
    wr        = 1'b0;
    res       = '0;
    if (exp_valid) begin
      case (ins[6:0])
        OPC_LUI: begin
          wr  = 1'b1;
          res = imm_u;
        end
        OPC_AUIPC: begin
          wr  = 1'b1;
          res = ipc + imm_u;
        end
        OPC_JAL: begin
          wr      = 1'b1;
          res     = ipc + 32'd4;
          exp_npc = ipc + imm_j;
        end
        OPC_JALR: begin
          wr      = 1'b1;
          res     = ipc + 32'd4;
          exp_npc = (a + imm_i) & 32'hffff_fffe;
        end
        OPC_BRANCH: begin
          taken = branch_ref(f3, a, b);
          if (taken) begin
            exp_npc = ipc + imm_b;
          end
          exp_misp = (pred != taken);
        end
        OPC_LOAD: begin
          wr  = 1'b1;
          res = load_ref(f3, a + imm_i);
        end
        OPC_STORE:  store_ref(f3, a + imm_s, b);
        OPC_OP_IMM: begin
          wr  = 1'b1;
          res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
        end
        OPC_OP: begin
          wr  = 1'b1;
          res = alu_ref(f3, ins[30], a, b);
        end
        OPC_SYSTEM: model_halt = 1'b1;
        default: ;
      endcase
      if (wr && rd != 5'd0) begin
        exp_wen        = 1'b1;
        model_regs[rd] = res;
      end
    end
    exp_data = res;
    exp_halt = model_halt;
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    assert (actual === expected) else begin
      $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
      $display("Finished with errors");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs();
    check_value("result_valid", {31'd0, result_valid}, {31'd0, exp_valid});
    check_value("halt", {31'd0, halt}, {31'd0, exp_halt});
    check_value("wb_en", {31'd0, wb_en}, {31'd0, exp_wen});
    check_value("mispredict", {31'd0, mispredict}, {31'd0, exp_misp});
    if (exp_valid) begin
      check_value("next_pc", next_pc, exp_npc);
    end
    // Payload only matters for a register write
    if (exp_wen) begin
      check_value("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd});
      check_value("wb_data", wb_data, exp_data);
    end
  endtask

  // Drive at the edge, check the previous result mid-cycle, then predict
  task automatic issue(input logic v, input word_t ins, input word_t ipc, input logic pred);
    @(posedge clk);
    instr_valid <= v;
    instr       <= ins;
    pc          <= ipc;
    prediction  <= pred;
    @(negedge clk);
    check_outputs();
    predict(v, ins, ipc, pred);
  endtask

  initial begin
    word_t ins;
    word_t ipc;
    logic  v;
    logic  pred;
    int    n;
    reset       <= 1'b1;
    instr_valid <= 1'b0;
    instr       <= '0;
    pc          <= '0;
    prediction  <= 1'b0;
    exp_valid  = 1'b0;
    exp_wen    = 1'b0;
    exp_misp   = 1'b0;
    exp_halt   = 1'b0;
    model_halt = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // Random stream, strobe high about three cycles in four
    n = 0;
    while (n < N_RANDOM) begin
      v = (rand_below(4) != 0);
      gen_instr(ins);
      ipc  = word_t'($random(seed)) & 32'hffff_fffc;
      pred = (rand_below(2) == 1);
      issue(v, ins, ipc, pred);
      if (v) begin
        n++;
      end
    end

    // Read back every register through addi rd, rd, 0
    for (int r = 1; r < 32; r++) begin
      issue(1'b1, {12'd0, reg_addr_t'(r), 3'b000, reg_addr_t'(r), OPC_OP_IMM}, '0, 1'b0);
    end
    // Read back every memory word with lw x1
    for (int i = 0; i < DMEM_WORDS; i++) begin
      issue(1'b1, {4'd0, 6'(i), 2'b00, 5'd0, 3'b010, 5'd1, OPC_LOAD}, '0, 1'b0);
    end

    // ecall halts the stage
    issue(1'b1, {25'd0, OPC_SYSTEM}, '0, 1'b0);
    // Strobes after the halt must be ignored
    for (int i = 0; i < 16; i++) begin
      gen_instr(ins);
      issue(1'b1, ins, word_t'($random(seed)) & 32'hffff_fffc, 1'b0);
    end
    issue(1'b0, '0, '0, 1'b0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
source/rv32_pkg.sv
source/decode_if.sv
source/alu.sv
source/reg_file.sv
source/control_unit.sv
source/branch_res.sv
source/data_memory.sv
source/execute_stage.sv
testbench/execute_properties.sv
testbench/execute_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module execute_tb \
  -Mdir obj_dir -o execute_sim \
  -f src.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/execute_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

exit 0
